// File: verilog/exec_config.svh
/*
 * Execute stage configuration
 * Datapath, program counter, sequence-number and register-address widths
 */

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ------------------------------------------------
// Datapath
// ------------------------------------------------

`define EXEC_DATA_BITS 32  // Operand and result width
`define EXEC_ADDR_BITS 32  // Program counter width

// ------------------------------------------------
// Tags
// ------------------------------------------------

`define EXEC_SEQ_BITS  5   // Sequence number, up to 32 in flight
`define EXEC_REG_BITS  5   // Destination register address

`endif

// File: verilog/exec_pkg.sv
/*
 * Execute stage types
 * Micro-op encoding, issue and writeback payloads, unit class decode
 */

`include "exec_config.svh"

package exec_pkg;

  // ------------------------------------------------
  // Micro-ops
  // ------------------------------------------------

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SRA   = 4'd7,
    OP_SLT   = 4'd8,   // Signed less-than, gives 1 or 0
    OP_MUL   = 4'd9,   // Low half of product
    OP_MULH  = 4'd10,  // High half, signed by signed
    OP_MULHU = 4'd11   // High half, unsigned by unsigned
  } uop_e;

  // ------------------------------------------------
  // Payloads
  // ------------------------------------------------

  // Decode to execute
  typedef struct packed {
    logic [`EXEC_ADDR_BITS-1:0] pc;
    logic [`EXEC_SEQ_BITS-1:0]  seq_num;
    logic [`EXEC_DATA_BITS-1:0] op1;
    logic [`EXEC_DATA_BITS-1:0] op2;
    logic [`EXEC_REG_BITS-1:0]  waddr;
    uop_e                       uop;
  } issue_msg_t;

  // Execute to writeback
  typedef struct packed {
    logic [`EXEC_ADDR_BITS-1:0] pc;
    logic [`EXEC_SEQ_BITS-1:0]  seq_num;
    logic [`EXEC_REG_BITS-1:0]  waddr;
    logic [`EXEC_DATA_BITS-1:0] wdata;
  } wb_msg_t;

  // True for ops handled by the multiplier
  function automatic logic is_mul_op(input uop_e uop);
    return (uop == OP_MUL) || (uop == OP_MULH) || (uop == OP_MULHU);
  endfunction

endpackage

// File: verilog/exec_dispatch.sv
/*
 * Issue dispatcher
 * Steers each micro-op to the ALU or the multiplier by op class
 */

`timescale 1ns/1ps

module exec_dispatch (
  // Issue from decode
  input  logic                 in_val,
  input  exec_pkg::issue_msg_t in_msg,
  output logic                 in_rdy,

  // ALU side
  output logic                 alu_val,
  input  logic                 alu_rdy,

  // Multiplier side
  output logic                 mul_val,
  input  logic                 mul_rdy
);

  // ------------------------------------------------
  // Class decode
  // ------------------------------------------------

  logic sel_mul;  // High steers to the multiplier

  // Only place the unit choice is made
  assign sel_mul = exec_pkg::is_mul_op(in_msg.uop);

  // ------------------------------------------------
  // Handshake steering
  // ------------------------------------------------

  // At most one unit sees a valid
  assign alu_val = in_val & ~sel_mul;
  assign mul_val = in_val &  sel_mul;

  // Ready comes back from the chosen unit only,
  // the other unit's ready is ignored this cycle
  always_comb begin
    if (sel_mul) begin
      in_rdy = mul_rdy;
    end else begin
      in_rdy = alu_rdy;
    end
  end

endmodule

// File: verilog/alu_unit.sv
/*
 * Integer ALU execute unit
 * One registered slot, result computed from the held operands
 */

`timescale 1ns/1ps
`include "exec_config.svh"

module alu_unit (
  input  logic                 clk,
  input  logic                 rst,

  // Issue side
  input  logic                 in_val,
  input  exec_pkg::issue_msg_t in_msg,
  output logic                 in_rdy,

  // Writeback side
  output logic                 out_val,
  output exec_pkg::wb_msg_t    out_msg,
  input  logic                 out_rdy
);

  localparam int W          = `EXEC_DATA_BITS;
  localparam int SHAMT_BITS = $clog2(W);  // 5 for a 32-bit datapath

  // ------------------------------------------------
  // Input slot
  // ------------------------------------------------

  logic                 slot_val;
  exec_pkg::issue_msg_t slot_msg;
  logic                 in_xfer;
  logic                 out_xfer;

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // Fill on issue, drain on writeback, else hold
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_val <= 1'b0;
    end else if (in_xfer) begin
      slot_val <= 1'b1;            // Refill wins over drain
    end else if (out_xfer) begin
      slot_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      slot_msg <= in_msg;
    end
  end

  // Empty slot or draining slot can take a new op
  assign in_rdy  = out_rdy | ~slot_val;
  assign out_val = slot_val;

  // ------------------------------------------------
  // Arithmetic
  // ------------------------------------------------

  logic [W-1:0]          op1;
  logic [W-1:0]          op2;
  logic [SHAMT_BITS-1:0] shamt;
  logic [W-1:0]          result;

  assign op1   = slot_msg.op1;
  assign op2   = slot_msg.op2;
  assign shamt = op2[SHAMT_BITS-1:0];  // Low bits of op2 only

  always_comb begin
    case (slot_msg.uop)
      exec_pkg::OP_ADD: result = op1 + op2;
      exec_pkg::OP_SUB: result = op1 - op2;
      exec_pkg::OP_AND: result = op1 & op2;
      exec_pkg::OP_OR:  result = op1 | op2;
      exec_pkg::OP_XOR: result = op1 ^ op2;
      exec_pkg::OP_SLL: result = op1 << shamt;
      exec_pkg::OP_SRL: result = op1 >> shamt;
      exec_pkg::OP_SRA: result = $signed(op1) >>> shamt;  // Sign fill
      exec_pkg::OP_SLT: result = {{(W-1){1'b0}}, ($signed(op1) < $signed(op2))};
      default:          result = '0;  // Multiplier ops never land here
    endcase
  end

  // ------------------------------------------------
  // Writeback payload
  // ------------------------------------------------

  always_comb begin
    out_msg.pc      = slot_msg.pc;
    out_msg.seq_num = slot_msg.seq_num;
    out_msg.waddr   = slot_msg.waddr;
    out_msg.wdata   = result;
  end

endmodule

// File: verilog/mul_unit.sv
/*
 * Pipelined multiplier execute unit
 * Two stages, MUL, MULH and MULHU, each stage stalls on its own
 */

`timescale 1ns/1ps
`include "exec_config.svh"

module mul_unit (
  input  logic                 clk,
  input  logic                 rst,

  // Issue side
  input  logic                 in_val,
  input  exec_pkg::issue_msg_t in_msg,
  output logic                 in_rdy,

  // Writeback side
  output logic                 out_val,
  output exec_pkg::wb_msg_t    out_msg,
  input  logic                 out_rdy
);

  localparam int W = `EXEC_DATA_BITS;

  // ------------------------------------------------
  // Stage control
  // ------------------------------------------------

  logic s1_val;     // Operands held in stage 1
  logic s2_val;     // Result held in stage 2
  logic s2_rdy;     // Stage 2 free or draining
  logic in_xfer;

  assign s2_rdy  = ~s2_val | out_rdy;
  assign in_rdy  = ~s1_val | s2_rdy;   // Stage 1 frees when it moves on
  assign in_xfer = in_val & in_rdy;

  // ------------------------------------------------
  // Stage 1: operand registers and product
  // ------------------------------------------------

  exec_pkg::issue_msg_t s1_msg;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
    end else if (in_xfer) begin
      s1_val <= 1'b1;
    end else if (s2_rdy) begin
      s1_val <= 1'b0;   // Moved into stage 2, or was already empty
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      s1_msg <= in_msg;
    end
  end

  logic                  signed_op;  // Only MULH treats operands as signed
  logic signed [W:0]     op1_ext;    // One extra bit carries the sign
  logic signed [W:0]     op2_ext;
  logic signed [2*W+1:0] product_ext;
  logic [2*W-1:0]        product;

  assign signed_op = (s1_msg.uop == exec_pkg::OP_MULH);

  always_comb begin
    op1_ext     = $signed({signed_op & s1_msg.op1[W-1], s1_msg.op1});
    op2_ext     = $signed({signed_op & s1_msg.op2[W-1], s1_msg.op2});
    product_ext = op1_ext * op2_ext;
    product     = product_ext[2*W-1:0];  // Full product
  end

  // Half select, low half for MUL
  logic [W-1:0] s1_result;

  always_comb begin
    if (s1_msg.uop == exec_pkg::OP_MUL) begin
      s1_result = product[W-1:0];
    end else begin
      s1_result = product[2*W-1:W];  // MULH and MULHU
    end
  end

  // ------------------------------------------------
  // Stage 2: result register
  // ------------------------------------------------

  exec_pkg::wb_msg_t s2_msg;
  exec_pkg::wb_msg_t s2_next;

  always_comb begin
    s2_next.pc      = s1_msg.pc;
    s2_next.seq_num = s1_msg.seq_num;
    s2_next.waddr   = s1_msg.waddr;
    s2_next.wdata   = s1_result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_val <= 1'b0;
    end else if (s2_rdy) begin
      s2_val <= s1_val;   // Bubble in when stage 1 is empty
    end
  end

  always_ff @(posedge clk) begin
    if (s2_rdy && s1_val) begin
      s2_msg <= s2_next;
    end
  end

  assign out_val = s2_val;
  assign out_msg = s2_msg;

endmodule

// File: verilog/wb_arbiter.sv
/*
 * Writeback arbiter
 * Round-robin join of two result streams onto one writeback port
 */

`timescale 1ns/1ps

module wb_arbiter (
  input  logic              clk,
  input  logic              rst,

  // Requester 0
  input  logic              req0_val,
  input  exec_pkg::wb_msg_t req0_msg,
  output logic              req0_rdy,

  // Requester 1
  input  logic              req1_val,
  input  exec_pkg::wb_msg_t req1_msg,
  output logic              req1_rdy,

  // Writeback port
  output logic              out_val,
  output exec_pkg::wb_msg_t out_msg,
  input  logic              out_rdy
);

  // ------------------------------------------------
  // Grant state
  // ------------------------------------------------

  logic prio;     // Favored requester, 0 after reset
  logic hold;     // Last grant stalled, keep it
  logic gnt_q;    // Grant of the last cycle
  logic gnt;      // Grant this cycle, 1 selects requester 1
  logic xfer;

  // Round robin unless a stalled grant is pending
  always_comb begin
    if (hold) begin
      gnt = gnt_q;
    end else if (prio) begin
      gnt = req1_val | ~req0_val;
    end else begin
      gnt = req1_val & ~req0_val;
    end
  end

  assign xfer = out_val & out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio  <= 1'b0;
      hold  <= 1'b0;
      gnt_q <= 1'b0;
    end else begin
      hold  <= out_val & ~out_rdy;   // Offered but not taken
      gnt_q <= gnt;
      if (xfer) begin
        prio <= ~gnt;                // Move past the winner
      end
    end
  end

  // ------------------------------------------------
  // Output mux and ready return
  // ------------------------------------------------

  assign out_val  = gnt ? req1_val : req0_val;
  assign out_msg  = gnt ? req1_msg : req0_msg;

  assign req0_rdy = out_rdy & ~gnt;  // Loser sees no ready
  assign req1_rdy = out_rdy &  gnt;

endmodule

// File: verilog/exec_top.sv
/*
 * Execute stage top level
 * Dispatcher, ALU, multiplier and shared writeback arbiter
 */

`timescale 1ns/1ps

module exec_top (
  input  logic                 clk,
  input  logic                 rst,

  // Issue from decode
  input  logic                 in_val,
  output logic                 in_rdy,
  input  exec_pkg::issue_msg_t in_msg,

  // Writeback
  output logic                 out_val,
  input  logic                 out_rdy,
  output exec_pkg::wb_msg_t    out_msg
);

  // ------------------------------------------------
  // Internal streams
  // ------------------------------------------------

  logic              alu_in_val;   // Dispatch to ALU
  logic              alu_in_rdy;
  logic              mul_in_val;   // Dispatch to multiplier
  logic              mul_in_rdy;

  logic              alu_wb_val;   // ALU to arbiter
  logic              alu_wb_rdy;
  exec_pkg::wb_msg_t alu_wb_msg;
  logic              mul_wb_val;   // Multiplier to arbiter
  logic              mul_wb_rdy;
  exec_pkg::wb_msg_t mul_wb_msg;

  // ------------------------------------------------
  // Blocks
  // ------------------------------------------------

  exec_dispatch u_dispatch (
    .in_val  (in_val),
    .in_msg  (in_msg),
    .in_rdy  (in_rdy),
    .alu_val (alu_in_val),
    .alu_rdy (alu_in_rdy),
    .mul_val (mul_in_val),
    .mul_rdy (mul_in_rdy)
  );

  // Both units see the issue payload unchanged
  alu_unit u_alu (
    .clk     (clk),
    .rst     (rst),
    .in_val  (alu_in_val),
    .in_msg  (in_msg),
    .in_rdy  (alu_in_rdy),
    .out_val (alu_wb_val),
    .out_msg (alu_wb_msg),
    .out_rdy (alu_wb_rdy)
  );

  mul_unit u_mul (
    .clk     (clk),
    .rst     (rst),
    .in_val  (mul_in_val),
    .in_msg  (in_msg),
    .in_rdy  (mul_in_rdy),
    .out_val (mul_wb_val),
    .out_msg (mul_wb_msg),
    .out_rdy (mul_wb_rdy)
  );

  // ALU is requester 0, favored after reset
  wb_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .req0_val (alu_wb_val),
    .req0_msg (alu_wb_msg),
    .req0_rdy (alu_wb_rdy),
    .req1_val (mul_wb_val),
    .req1_msg (mul_wb_msg),
    .req1_rdy (mul_wb_rdy),
    .out_val  (out_val),
    .out_msg  (out_msg),
    .out_rdy  (out_rdy)
  );

endmodule

// File: test/exec_tb.sv
/*
 * Execute stage testbench
 * Reference model and scoreboard by seq_num, directed and random stimulus
 */

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_tb;

  localparam int W       = `EXEC_DATA_BITS;
  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic                 clk;
  logic                 rst;
  logic                 in_val;
  logic                 in_rdy;
  exec_pkg::issue_msg_t in_msg;
  logic                 out_val;
  logic                 out_rdy;
  exec_pkg::wb_msg_t    out_msg;

  exec_top UUT (
    .clk     (clk),
    .rst     (rst),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  // ------------------------------------------------
  // Scoreboard and bookkeeping
  // ------------------------------------------------

  exec_pkg::wb_msg_t exp_msg [0:31];     // Expected writeback per seq_num
  logic              pending [0:31];
  int                issue_cyc [0:31];   // Cycle of the issue transfer
  logic [3:0]        issued_uop [0:31];  // Op class lookup for latency
  int                outstanding;
  int                cyc;
  int                errors;
  int                timeouts;
  int                issued;
  int                written;
  logic              timed_out;
  logic              lat_check;          // Idle latency phase
  logic              stall_en;           // Random out_rdy stalls
  logic              rst_q;
  logic              stall_q;            // Offered but not taken last edge
  exec_pkg::wb_msg_t held_msg;
  logic [4:0]        seq_ctr;
  logic [31:0]       rng_state;
  logic [W-1:0]      corners [0:4];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Multiplier class by encoding, codes 9 to 11
  function automatic logic mul_class(input logic [3:0] uop);
    return (uop >= 4'd9) && (uop <= 4'd11);
  endfunction

  // Reference results from the ISA rules
  function automatic logic [W-1:0] ref_result(input logic [3:0] uop,
                                              input logic [W-1:0] a,
                                              input logic [W-1:0] b);
    logic [4:0]     sh;
    logic [2*W-1:0] prod;
    sh = b[4:0];
    case (uop)
      4'd0:    return a + b;
      4'd1:    return a - b;
      4'd2:    return a & b;
      4'd3:    return a | b;
      4'd4:    return a ^ b;
      4'd5:    return a << sh;
      4'd6:    return a >> sh;
      4'd7:    return (a >> sh) | (a[W-1] ? ~({W{1'b1}} >> sh) : '0);  // Sign fill
      4'd8:    return (a[W-1] != b[W-1]) ? W'(a[W-1]) : W'(a < b);
      4'd9: begin
        prod = a * b;
        return prod[W-1:0];
      end
      4'd10: begin
        prod = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};  // Signed product mod 2^64
        return prod[2*W-1:W];
      end
      4'd11: begin
        prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        return prod[2*W-1:W];
      end
      default: return '0;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic timeout_hit(input string what);
    $display("Timeout at %0t ns: no progress while waiting for %s", $time, what);
    timeouts++;
    timed_out = 1'b1;
  endtask

  // ------------------------------------------------
  // Monitor, sampled on the rising edge
  // ------------------------------------------------

  task automatic record_issue(input exec_pkg::issue_msg_t m);
    exp_msg[m.seq_num].pc      = m.pc;
    exp_msg[m.seq_num].seq_num = m.seq_num;
    exp_msg[m.seq_num].waddr   = m.waddr;
    exp_msg[m.seq_num].wdata   = ref_result(m.uop, m.op1, m.op2);
    issued_uop[m.seq_num] = m.uop;
    pending[m.seq_num]    = 1'b1;
    issue_cyc[m.seq_num]  = cyc;
    outstanding++;
    issued++;
  endtask

  task automatic check_writeback(input exec_pkg::wb_msg_t m);
    int exp_lat;
    if (!pending[m.seq_num]) begin
      report_error($sformatf("seq %0d written back but not pending", m.seq_num));
    end else begin
      assert (m == exp_msg[m.seq_num])
        else report_error($sformatf("seq %0d expected %h, got %h",
                                    m.seq_num, exp_msg[m.seq_num], m));
      if (lat_check) begin
        exp_lat = mul_class(issued_uop[m.seq_num]) ? 2 : 1;
        assert (cyc - issue_cyc[m.seq_num] == exp_lat)
          else report_error($sformatf("seq %0d latency %0d, expected %0d",
                                      m.seq_num, cyc - issue_cyc[m.seq_num], exp_lat));
      end
      pending[m.seq_num] = 1'b0;
      outstanding--;
      written++;
    end
  endtask

  always @(posedge clk) begin
    if ((rst && rst_q) || (rst_q && !rst)) begin
      assert (!out_val) else report_error("out_val high in or right after reset");
    end
    if (rst_q && !rst) begin
      assert (in_rdy) else report_error("in_rdy low right after reset");
    end
    if (!rst) begin
      if (stall_q) begin
        assert (out_val && out_msg == held_msg)
          else report_error("out_msg not held under back-pressure");
      end
      if (in_val && in_rdy) record_issue(in_msg);
      if (out_val && out_rdy) check_writeback(out_msg);
    end
    stall_q  = !rst && out_val && !out_rdy;
    held_msg = out_msg;
    rst_q    = rst;
    cyc++;
  end

  // ------------------------------------------------
  // Driver, falling edge
  // ------------------------------------------------

  task automatic next_cycle();
    @(negedge clk);
    if (stall_en) begin
      out_rdy = (next_rand() % 3) != 0;  // Stall about a third of cycles
    end else begin
      out_rdy = 1'b1;
    end
  endtask

  task automatic issue_op(input logic [3:0] uop, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    exec_pkg::issue_msg_t m;
    int   waits;
    logic accepted;
    waits = 0;
    while (pending[seq_ctr] && !timed_out) begin  // Tag still in flight
      next_cycle();
      waits++;
      if (waits > TIMEOUT) timeout_hit("a free sequence number");
    end
    if (!timed_out) begin
      m.pc      = next_rand();
      m.seq_num = seq_ctr;
      m.op1     = a;
      m.op2     = b;
      m.waddr   = next_rand();
      m.uop     = exec_pkg::uop_e'(uop);
      in_msg    = m;
      in_val    = 1'b1;
      accepted  = 1'b0;
      waits     = 0;
      while (!accepted && !timed_out) begin
        @(posedge clk);
        accepted = in_rdy;  // Handshake seen at this edge
        next_cycle();
        waits++;
        if (!accepted && waits > TIMEOUT) timeout_hit("the issue handshake");
      end
      in_val  = 1'b0;
      seq_ctr = seq_ctr + 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waits;
    waits = 0;
    while (outstanding != 0 && !timed_out) begin
      next_cycle();
      waits++;
      if (waits > TIMEOUT) timeout_hit("outstanding results to drain");
    end
  endtask

  function automatic logic [W-1:0] rand_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] == 3'd0) return corners[r[5:3] % 5];  // Corner value now and then
    return next_rand();
  endfunction

  initial begin
    int gap;
    rng_state   = 32'd69;
    corners[0]  = '0;
    corners[1]  = '1;
    corners[2]  = 32'h8000_0000;  // Most negative
    corners[3]  = 32'd31;         // Largest shift
    corners[4]  = 32'h7fff_ffff;
    for (int i = 0; i < 32; i++) pending[i] = 1'b0;
    {outstanding, cyc, errors, timeouts, issued, written} = '0;
    {timed_out, lat_check, stall_en, rst_q, stall_q} = '0;
    seq_ctr = '0;
    rst     = 1'b1;
    in_val  = 1'b0;
    in_msg  = '0;
    out_rdy = 1'b1;
    repeat (8) @(posedge clk);  // Reset held over 8 rising edges
    @(negedge clk);
    rst = 1'b0;

    // Lone ALU and MUL ops on an idle pipeline
    lat_check = 1'b1;
    issue_op(4'd0, 32'd5, 32'd7);
    wait_drain();
    issue_op(4'd9, 32'd6, 32'd7);
    wait_drain();
    lat_check = 1'b0;

    // Every op over corner operand pairs
    for (int u = 0; u < 12; u++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
          if (!timed_out) issue_op(u[3:0], corners[i], corners[j]);
    wait_drain();

    // Random ops, gaps and writeback stalls
    stall_en = 1'b1;
    for (int n = 0; n < 400 && !timed_out; n++) begin
      issue_op(4'(next_rand() % 12), rand_operand(), rand_operand());
      gap = next_rand() % 4;
      repeat (gap) next_cycle();
    end
    stall_en = 1'b0;
    wait_drain();

    $display("Done: %0d issued, %0d written back, %0d errors, %0d timeouts",
             issued, written, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_dispatch.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/wb_arbiter.sv
verilog/exec_top.sv
test/exec_tb.sv
